// ==== decode_stage.f ====
rtl/rv_decode_pkg.sv
rtl/instr_decoder.sv
rtl/imm_gen.sv
rtl/reg_file.sv
rtl/issue_ctrl.sv
rtl/decode_stage.sv
testbench/tb_decode_stage.sv

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
  import rv_decode_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  fe_latch_t fe,
  input  wb_t       wb,
  input  logic      br_mispred,
  output logic      stall,
  output de_latch_t de_latch
);

  decode_info_t    info;
  logic [xlen-1:0] rs1_val;
  logic [xlen-1:0] rs2_val;
  logic [xlen-1:0] imm;

  ////////////////////////////////////////////////////////////////////////////
  // combinational decode
  ////////////////////////////////////////////////////////////////////////////

  instr_decoder i_decoder (
    .inst (fe.inst),
    .info (info)
  );

  imm_gen i_imm_gen (
    .inst    (fe.inst),
    .imm_fmt (info.imm_fmt),
    .imm     (imm)
  );

  // operands are read straight from the decoded register fields
  reg_file i_reg_file (
    .clk     (clk),
    .reset   (reset),
    .wb      (wb),
    .rs1     (info.rs1),
    .rs2     (info.rs2),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val)
  );

  ////////////////////////////////////////////////////////////////////////////
  // hazard check and latch
  ////////////////////////////////////////////////////////////////////////////

  issue_ctrl i_issue_ctrl (
    .clk        (clk),
    .reset      (reset),
    .fe         (fe),
    .info       (info),
    .rs1_val    (rs1_val),
    .rs2_val    (rs2_val),
    .imm        (imm),
    .wb         (wb),
    .br_mispred (br_mispred),
    .stall      (stall),
    .de_latch   (de_latch)
  );

endmodule

// ==== rtl/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen
  import rv_decode_pkg::*;
(
  input  logic [inst_bits-1:0] inst,
  input  imm_fmt_e             imm_fmt,
  output logic [xlen-1:0]      imm
);

  // sign bit of every format sits in inst[31]
  logic sign;

  assign sign = inst[31];

  always_comb begin
    case (imm_fmt)
      imm_i: begin
        imm = {{21{sign}}, inst[30:20]};
      end
      imm_s: begin
        imm = {{21{sign}}, inst[30:25], inst[11:7]};
      end
      imm_b: begin
        // branch offsets are in halfwords
        imm = {{20{sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      imm_u: begin
        imm = {inst[31:12], 12'b0};
      end
      imm_j: begin
        imm = {{12{sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder
  import rv_decode_pkg::*;
(
  input  logic [inst_bits-1:0] inst,
  output decode_info_t         info
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  op_e        op;
  imm_fmt_e   imm_fmt;
  logic       use_rs1;
  logic       use_rs2;
  logic       is_br;
  logic       is_jmp;
  logic       rd_mem;
  logic       wr_mem;
  logic       writes_rd;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  ////////////////////////////////////////////////////////////////////////////
  // opcode match
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    op = op_invalid;
    case (opcode)
      op_alu_r: begin
        if (funct7 == f7_base) begin
          case (funct3)
            f3_add_sub: op = iop_add;
            f3_sll:     op = iop_sll;
            f3_slt:     op = iop_slt;
            f3_sltu:    op = iop_sltu;
            f3_xor:     op = iop_xor;
            f3_srl_sra: op = iop_srl;
            f3_or:      op = iop_or;
            f3_and:     op = iop_and;
            default:    op = op_invalid;
          endcase
        end else if (funct7 == f7_alt) begin
          if (funct3 == f3_add_sub)
            op = iop_sub;
          else if (funct3 == f3_srl_sra)
            op = iop_sra;
        end else if (funct7 == f7_muldiv && funct3 == f3_mul) begin
          op = iop_mul;
        end
      end
      op_alu_i: begin
        case (funct3)
          f3_add_sub: op = iop_addi;
          f3_slt:     op = iop_slti;
          f3_sltu:    op = iop_sltiu;
          f3_xor:     op = iop_xori;
          f3_or:      op = iop_ori;
          f3_and:     op = iop_andi;
          // shifts keep a funct7 in the upper immediate bits
          f3_sll:     op = (funct7 == f7_base) ? iop_slli : op_invalid;
          f3_srl_sra: begin
            if (funct7 == f7_base)
              op = iop_srli;
            else if (funct7 == f7_alt)
              op = iop_srai;
          end
          default:    op = op_invalid;
        endcase
      end
      op_lui:   op = iop_lui;
      op_auipc: op = iop_auipc;
      op_load:  op = (funct3 == f3_lw) ? iop_lw : op_invalid;
      op_store: op = (funct3 == f3_sw) ? iop_sw : op_invalid;
      op_jal:   op = iop_jal;
      op_jalr:  op = (funct3 == f3_jalr) ? iop_jalr : op_invalid;
      op_branch: begin
        case (funct3)
          f3_beq:  op = iop_beq;
          f3_bne:  op = iop_bne;
          f3_blt:  op = iop_blt;
          f3_bge:  op = iop_bge;
          f3_bltu: op = iop_bltu;
          f3_bgeu: op = iop_bgeu;
          default: op = op_invalid;
        endcase
      end
      default: op = op_invalid;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // per class attributes
  ////////////////////////////////////////////////////////////////////////////

  // keyed on op so an unmatched encoding carries no side effects
  always_comb begin
    imm_fmt   = imm_none;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    is_br     = 1'b0;
    is_jmp    = 1'b0;
    rd_mem    = 1'b0;
    wr_mem    = 1'b0;
    writes_rd = 1'b0;
    case (op)
      iop_add, iop_sub, iop_and, iop_or, iop_xor, iop_slt, iop_sltu,
      iop_sll, iop_srl, iop_sra, iop_mul: begin
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        writes_rd = 1'b1;
      end
      iop_addi, iop_andi, iop_ori, iop_xori, iop_slti, iop_sltiu,
      iop_slli, iop_srli, iop_srai: begin
        imm_fmt   = imm_i;
        use_rs1   = 1'b1;
        writes_rd = 1'b1;
      end
      iop_lui, iop_auipc: begin
        imm_fmt   = imm_u;
        writes_rd = 1'b1;
      end
      iop_lw: begin
        imm_fmt   = imm_i;
        use_rs1   = 1'b1;
        rd_mem    = 1'b1;
        writes_rd = 1'b1;
      end
      iop_sw: begin
        imm_fmt = imm_s;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        wr_mem  = 1'b1;
      end
      iop_jal: begin
        imm_fmt   = imm_j;
        is_jmp    = 1'b1;
        writes_rd = 1'b1;
      end
      iop_jalr: begin
        imm_fmt   = imm_i;
        use_rs1   = 1'b1;
        is_jmp    = 1'b1;
        writes_rd = 1'b1;
      end
      iop_beq, iop_bne, iop_blt, iop_bge, iop_bltu, iop_bgeu: begin
        imm_fmt = imm_b;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        is_br   = 1'b1;
      end
      default: ;
    endcase
  end

  assign info.op      = op;
  assign info.imm_fmt = imm_fmt;
  assign info.rs1     = inst[19:15];
  assign info.rs2     = inst[24:20];
  assign info.rd      = inst[11:7];
  assign info.use_rs1 = use_rs1;
  assign info.use_rs2 = use_rs2;
  assign info.is_br   = is_br;
  assign info.is_jmp  = is_jmp;
  assign info.rd_mem  = rd_mem;
  assign info.wr_mem  = wr_mem;
  // x0 is hardwired and a write to it is dropped here
  assign info.wr_reg  = writes_rd && (info.rd != '0);

endmodule

// ==== rtl/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl
  import rv_decode_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  fe_latch_t       fe,
  input  decode_info_t    info,
  input  logic [xlen-1:0] rs1_val,
  input  logic [xlen-1:0] rs2_val,
  input  logic [xlen-1:0] imm,
  input  wb_t             wb,
  input  logic            br_mispred,
  output logic            stall,
  output de_latch_t       de_latch
);

  // one bit per register with a write still in flight
  logic [reg_num-1:0] scoreboard;
  logic               hazard;
  logic               accept;
  de_latch_t          next_latch;

  assign hazard = (info.use_rs1 && scoreboard[info.rs1]) ||
                  (info.use_rs2 && scoreboard[info.rs2]);
  assign stall  = (fe.valid && hazard) || br_mispred;
  assign accept = fe.valid && !stall;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      scoreboard <= '0;
    end else begin
      if (wb.wr_reg)
        scoreboard[wb.wregno] <= 1'b0;
      // later assignment takes priority, the new producer owns rd
      if (accept && info.wr_reg)
        scoreboard[info.rd] <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // decode to execute latch
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    next_latch = '0;
    if (accept) begin
      next_latch.valid   = 1'b1;
      next_latch.pc      = fe.pc;
      next_latch.op      = info.op;
      next_latch.rs1_val = rs1_val;
      next_latch.rs2_val = rs2_val;
      next_latch.imm     = imm;
      next_latch.is_br   = info.is_br;
      next_latch.is_jmp  = info.is_jmp;
      next_latch.rd_mem  = info.rd_mem;
      next_latch.wr_mem  = info.wr_mem;
      next_latch.wr_reg  = info.wr_reg;
      next_latch.rd      = info.rd;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      de_latch <= '0;
    else
      de_latch <= next_latch;
  end

  a_x0_never_pending: assert property (@(posedge clk) disable iff (reset)
    !scoreboard[0]);

  a_bubble_after_stall: assert property (@(posedge clk) disable iff (reset)
    stall |=> !de_latch.valid);

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
  import rv_decode_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  wb_t                     wb,
  input  logic [reg_idx_bits-1:0] rs1,
  input  logic [reg_idx_bits-1:0] rs2,
  output logic [xlen-1:0]         rs1_val,
  output logic [xlen-1:0]         rs2_val
);

  // x0 has no storage
  logic [xlen-1:0] regs [1:reg_num-1];
  logic            wr_en;

  assign wr_en = wb.wr_reg && (wb.wregno != '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 1; i < reg_num; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wb.wregno] <= wb.regval;
    end
  end

  // write-first read, a pending writeback wins over the stored word
  function automatic logic [xlen-1:0] read_port(input logic [reg_idx_bits-1:0] idx);
    logic [xlen-1:0] val;
    if (idx == '0)
      val = '0;
    else if (wr_en && wb.wregno == idx)
      val = wb.regval;
    else
      val = regs[idx];
    return val;
  endfunction

  always_comb begin
    rs1_val = read_port(rs1);
    rs2_val = read_port(rs2);
  end

endmodule

// ==== rtl/rv_decode_pkg.sv ====
package rv_decode_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int xlen         = 32;
  localparam int inst_bits    = 32;
  localparam int reg_num      = 32;
  localparam int reg_idx_bits = 5;

  ////////////////////////////////////////////////////////////////////////////
  // rv32i encodings
  ////////////////////////////////////////////////////////////////////////////

  // major opcodes, inst[6:0]
  localparam logic [6:0] op_alu_r  = 7'b0110011;
  localparam logic [6:0] op_alu_i  = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;

  // funct3 for alu ops, register and immediate forms share these
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_mul     = 3'b000;

  // funct3 for memory, jalr and branches
  localparam logic [2:0] f3_lw   = 3'b010;
  localparam logic [2:0] f3_sw   = 3'b010;
  localparam logic [2:0] f3_jalr = 3'b000;
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // funct7, alt selects sub and sra
  localparam logic [6:0] f7_base   = 7'b0000000;
  localparam logic [6:0] f7_alt    = 7'b0100000;
  localparam logic [6:0] f7_muldiv = 7'b0000001;

  ////////////////////////////////////////////////////////////////////////////
  // internal types
  ////////////////////////////////////////////////////////////////////////////

  // zero is op_invalid so an all zero bubble never looks like a real op
  typedef enum logic [5:0] {
    op_invalid,
    iop_add, iop_sub, iop_and, iop_or, iop_xor, iop_slt, iop_sltu,
    iop_sll, iop_srl, iop_sra, iop_mul,
    iop_addi, iop_andi, iop_ori, iop_xori, iop_slti, iop_sltiu,
    iop_slli, iop_srli, iop_srai,
    iop_lui, iop_auipc, iop_lw, iop_sw, iop_jal, iop_jalr,
    iop_beq, iop_bne, iop_blt, iop_bge, iop_bltu, iop_bgeu
  } op_e;

  typedef enum logic [2:0] {
    imm_none, imm_i, imm_s, imm_b, imm_u, imm_j
  } imm_fmt_e;

  typedef struct packed {
    logic                  valid;
    logic [inst_bits-1:0]  inst;
    logic [xlen-1:0]       pc;
  } fe_latch_t;

  typedef struct packed {
    logic                    wr_reg;
    logic [reg_idx_bits-1:0] wregno;
    logic [xlen-1:0]         regval;
  } wb_t;

  typedef struct packed {
    op_e                     op;
    imm_fmt_e                imm_fmt;
    logic [reg_idx_bits-1:0] rs1;
    logic [reg_idx_bits-1:0] rs2;
    logic [reg_idx_bits-1:0] rd;
    logic                    use_rs1;
    logic                    use_rs2;
    logic                    is_br;
    logic                    is_jmp;
    logic                    rd_mem;
    logic                    wr_mem;
    logic                    wr_reg;
  } decode_info_t;

  typedef struct packed {
    logic                    valid;
    logic [xlen-1:0]         pc;
    op_e                     op;
    logic [xlen-1:0]         rs1_val;
    logic [xlen-1:0]         rs2_val;
    logic [xlen-1:0]         imm;
    logic                    is_br;
    logic                    is_jmp;
    logic                    rd_mem;
    logic                    wr_mem;
    logic                    wr_reg;
    logic [reg_idx_bits-1:0] rd;
  } de_latch_t;

endpackage

// ==== testbench/tb_decode_stage.sv ====
`timescale 1ns/1ps

module tb_decode_stage
  import rv_decode_pkg::*;
();

  localparam int clk_period  = 100;
  localparam int reset_turns = 3;

  // stall is taken in the driven cycle and the latch fields after the edge
  typedef struct packed {
    logic            stall;
    logic            valid;
    op_e             op;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_val;
    logic            wr_reg;
  } result_t;

  typedef struct packed {
    logic                 fe_valid;
    logic [inst_bits-1:0] inst;
    wb_t                  wb;
    logic                 br_mispred;
    result_t              exp;
  } row_t;

  logic      clk;
  logic      reset;
  fe_latch_t fe;
  wb_t       wb;
  logic      br_mispred;
  logic      stall;
  de_latch_t de_latch;

  row_t        rows[$];
  string       names[$];
  logic [31:0] lcg_state = 32'd45;
  logic        table_ready = 1'b0;
  int          pass_count = 0;
  int          fail_count = 0;

  decode_stage i_dut (
    .clk        (clk),
    .reset      (reset),
    .fe         (fe),
    .wb         (wb),
    .br_mispred (br_mispred),
    .stall      (stall),
    .de_latch   (de_latch)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // rv32i encoders with fields in isa order
  function logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                               input logic [4:0] rs1, input logic [2:0] f3,
                               input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                               input logic [2:0] f3, input logic [4:0] rd,
                               input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                               input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                               input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                               input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function wb_t writeback(input logic [4:0] regno, input logic [31:0] val);
    wb_t w;
    w.wr_reg = 1'b1;
    w.wregno = regno;
    w.regval = val;
    return w;
  endfunction

  task store_row(input string name, input logic fe_valid, input logic [31:0] inst,
                 input wb_t wb_in, input logic br, input result_t exp);
    row_t r;
    r.fe_valid   = fe_valid;
    r.inst       = inst;
    r.wb         = wb_in;
    r.br_mispred = br;
    r.exp        = exp;
    rows.push_back(r);
    names.push_back(name);
  endtask

  // accepted instruction that shows up in the latch one edge later
  task expect_issue(input string name, input logic [31:0] inst, input wb_t wb_in,
                    input op_e op, input logic [31:0] imm, input logic [31:0] rs1_val,
                    input logic wr_reg);
    result_t e;
    e.stall   = 1'b0;
    e.valid   = 1'b1;
    e.op      = op;
    e.imm     = imm;
    e.rs1_val = rs1_val;
    e.wr_reg  = wr_reg;
    store_row(name, 1'b1, inst, wb_in, 1'b0, e);
  endtask

  // bubble has every latch field zero
  task expect_bubble(input string name, input logic fe_valid, input logic [31:0] inst,
                     input wb_t wb_in, input logic br, input logic exp_stall);
    result_t e;
    e = '0;
    e.stall = exp_stall;
    e.op    = op_invalid;
    store_row(name, fe_valid, inst, wb_in, br, e);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test table
  ////////////////////////////////////////////////////////////////////////////

  task build_table();
    wb_t         none;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] v3;
    logic [31:0] v4;
    logic [31:0] add_x5;
    none = '0;
    v1 = lcg_next();
    v2 = lcg_next();
    v3 = lcg_next();
    v4 = lcg_next();
    // decode and immediates while every register is still zero
    expect_issue("add", r_type(7'h00, 0, 0, 3'd0, 20, 7'h33), none, iop_add, 0, 0, 1);
    expect_issue("sub", r_type(7'h20, 0, 0, 3'd0, 21, 7'h33), none, iop_sub, 0, 0, 1);
    expect_issue("mul", r_type(7'h01, 0, 0, 3'd0, 22, 7'h33), none, iop_mul, 0, 0, 1);
    expect_issue("sra", r_type(7'h20, 0, 0, 3'd5, 23, 7'h33), none, iop_sra, 0, 0, 1);
    expect_issue("addi_neg", i_type(12'hffb, 0, 3'd0, 24, 7'h13), none, iop_addi,
                 32'hffff_fffb, 0, 1);
    expect_issue("srai", i_type(12'h403, 0, 3'd5, 25, 7'h13), none, iop_srai,
                 32'h0000_0403, 0, 1);
    expect_issue("lui", u_type(20'habcde, 26, 7'h37), none, iop_lui, 32'habcd_e000, 0, 1);
    expect_issue("auipc", u_type(20'h12345, 27, 7'h17), none, iop_auipc,
                 32'h1234_5000, 0, 1);
    expect_issue("lw_neg", i_type(12'hff0, 0, 3'd2, 28, 7'h03), none, iop_lw,
                 32'hffff_fff0, 0, 1);
    expect_issue("sw_neg", s_type(12'hfec, 0, 0, 3'd2), none, iop_sw, 32'hffff_ffec, 0, 0);
    expect_issue("jal_neg", j_type(21'h1ff800, 29), none, iop_jal, 32'hffff_f800, 0, 1);
    expect_issue("jalr", i_type(12'd8, 0, 3'd0, 30, 7'h67), none, iop_jalr, 8, 0, 1);
    expect_issue("beq_neg", b_type(13'h1ff8, 0, 0, 3'd0), none, iop_beq,
                 32'hffff_fff8, 0, 0);
    expect_issue("bgeu", b_type(13'd100, 0, 0, 3'd7), none, iop_bgeu, 100, 0, 0);
    // register file writes followed by reads
    expect_bubble("wb_x1", 1'b0, 0, writeback(1, v1), 1'b0, 1'b0);
    expect_issue("read_x1", r_type(7'h00, 0, 1, 3'd0, 10, 7'h33), none, iop_add, 0, v1, 1);
    expect_issue("bypass_x2", r_type(7'h00, 0, 2, 3'd0, 11, 7'h33), writeback(2, v2),
                 iop_add, 0, v2, 1);
    // raw hazard on x5 where fetch holds the reader until writeback
    add_x5 = r_type(7'h00, 0, 5, 3'd0, 12, 7'h33);
    expect_issue("addi_x5", i_type(12'd7, 0, 3'd0, 5, 7'h13), none, iop_addi, 7, 0, 1);
    expect_bubble("raw_stall", 1'b1, add_x5, none, 1'b0, 1'b1);
    expect_bubble("raw_wb_x5", 1'b1, add_x5, writeback(5, v3), 1'b0, 1'b1);
    expect_issue("raw_issue", add_x5, none, iop_add, 0, v3, 1);
    // flush
    expect_bubble("mispred_addi", 1'b1, i_type(12'd1, 0, 3'd0, 13, 7'h13), none, 1'b1, 1'b1);
    expect_bubble("mispred_add", 1'b1, r_type(7'h00, 0, 1, 3'd0, 18, 7'h33), none,
                  1'b1, 1'b1);
    // x0 as a destination and as a source
    expect_issue("addi_x0", i_type(12'd9, 0, 3'd0, 0, 7'h13), none, iop_addi, 9, 0, 0);
    expect_issue("read_x0", r_type(7'h00, 0, 0, 3'd0, 14, 7'h33), none, iop_add, 0, 0, 1);
    expect_issue("wb_x0_same", r_type(7'h00, 0, 0, 3'd0, 15, 7'h33), writeback(0, v4),
                 iop_add, 0, 0, 1);
    expect_issue("read_x0_after", r_type(7'h00, 0, 0, 3'd0, 16, 7'h33), none,
                 iop_add, 0, 0, 1);
    // undefined opcode whose rs fields name pending x10 and x11
    expect_issue("undefined", r_type(7'h00, 11, 10, 3'd0, 3, 7'h7f), none, op_invalid,
                 0, 0, 0);
    expect_issue("after_undef", r_type(7'h00, 0, 3, 3'd0, 17, 7'h33), none, iop_add,
                 0, 0, 1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // drive and check
  ////////////////////////////////////////////////////////////////////////////

  task apply_row(input int idx);
    fe.valid   = rows[idx].fe_valid;
    fe.inst    = rows[idx].inst;
    fe.pc      = 32'h0000_0100 + 32'(idx) * 4;
    wb         = rows[idx].wb;
    br_mispred = rows[idx].br_mispred;
  endtask

  task check_row(input int idx, input logic stall_seen);
    result_t seen;
    result_t exp;
    exp          = rows[idx].exp;
    seen.stall   = stall_seen;
    seen.valid   = de_latch.valid;
    seen.op      = de_latch.op;
    seen.imm     = de_latch.imm;
    seen.rs1_val = de_latch.rs1_val;
    seen.wr_reg  = de_latch.wr_reg;
    if (seen !== exp) begin
      fail_count++;
      $write("MISMATCH %s expected stall=%b valid=%b op=%0d imm=%h rs1=%h wr=%b",
             names[idx], exp.stall, exp.valid, exp.op, exp.imm, exp.rs1_val,
             exp.wr_reg);
      $display(" actual stall=%b valid=%b op=%0d imm=%h rs1=%h wr=%b",
               seen.stall, seen.valid, seen.op, seen.imm, seen.rs1_val, seen.wr_reg);
    end else begin
      pass_count++;
      $display("PASS %s", names[idx]);
    end
  endtask

  initial begin
    logic stall_seen;
    reset      = 1'b1;
    fe         = '0;
    wb         = '0;
    br_mispred = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (reset_turns) @(posedge clk);
    #10 reset = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      apply_row(i);
      // stall is combinational and sampled mid cycle
      #40 stall_seen = stall;
      @(posedge clk);
      #5 check_row(i, stall_seen);
      #5;
    end
    fe = '0;
    wb = '0;
    br_mispred = 1'b0;
    $display("tests %0d, passed %0d, failed %0d", rows.size(), pass_count, fail_count);
    if (fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // watchdog allows four cycles per row plus reset
  initial begin
    wait (table_ready);
    #(rows.size() * 4 * clk_period + reset_turns * clk_period);
    $display("timeout: the test table did not finish in time");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
